/* rbus_pkg.sv */
package rbus_pkg;

  // --------------------------------------------------
  // ring geometry
  // --------------------------------------------------

  // priority levels, 3 is the highest
  localparam int PRIO_NUM = 4;
  localparam int PRIO_W = 2;

  // device and request id widths
  localparam int DEV_W = 4;
  localparam int RID_W = 4;

  // per-class request queue
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW = 4;

  // ring data word
  localparam int WORD_W = 32;

  // --------------------------------------------------
  // ring types
  // --------------------------------------------------

  // control field that travels beside each word
  // on data words it carries a request, on headers a grant
  typedef struct packed {
    logic              valid;
    // 1 means long packet
    logic              len;
    logic [PRIO_W-1:0] pp;
    logic [DEV_W-1:0]  did;
    logic [RID_W-1:0]  rid;
  } rbus_ctrl_t;

  // header layout, first word of a frame
  typedef struct packed {
    logic              frm_len;
    // kept for format compatibility, grant logic looks at ctrl valid
    logic              frm_used;
    logic [WORD_W-3:0] rsvd;
  } rbus_header_t;

  // header when sof is high, raw payload otherwise
  typedef union packed {
    rbus_header_t      header;
    logic [WORD_W-1:0] raw;
  } rbus_word_t;

  // one queued request, length is implied by the bank
  typedef struct packed {
    logic [PRIO_W-1:0] pri;
    logic [DEV_W-1:0]  dev;
    logic [RID_W-1:0]  rid;
  } rbus_req_t;

endpackage

/* rbus_req_sort.sv */
`timescale 1ns/1ps

module rbus_req_sort (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_sof,
  input  rbus_pkg::rbus_ctrl_t i_ctrl,
  input  logic [3:0]           i_af_s,
  input  logic [3:0]           i_af_l,
  output logic                 o_wr_s,
  output logic                 o_wr_l,
  output rbus_pkg::rbus_req_t  o_req,
  output logic                 o_skip,
  output logic                 o_used
);

  logic is_req;
  logic af_sel;
  logic hdr_used;

  // --------------------------------------------------
  // request detect
  // --------------------------------------------------

  // data word carrying a device request
  assign is_req = !i_sof & i_ctrl.valid;

  // almost-full of the target queue
  // flag already counts a write still in flight
  assign af_sel = i_ctrl.len ? i_af_l[i_ctrl.pp] : i_af_s[i_ctrl.pp];

  // header already taken by an earlier manager or device
  assign hdr_used = i_sof & i_ctrl.valid;

  // --------------------------------------------------
  // decision register
  // --------------------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_wr_s <= 1'b0;
      o_wr_l <= 1'b0;
      o_skip <= 1'b0;
      o_used <= 1'b0;
    end else begin
      // accept into the queue of matching length
      o_wr_s <= is_req & !i_ctrl.len & !af_sel;
      o_wr_l <= is_req & i_ctrl.len & !af_sel;
      // queue too full, request stays on the ring
      o_skip <= is_req & af_sel;
      o_used <= hdr_used;
    end
  end

  // request payload, qualified by the strobes
  always_ff @(posedge clk) begin
    o_req.pri <= i_ctrl.pp;
    o_req.dev <= i_ctrl.did;
    o_req.rid <= i_ctrl.rid;
  end

endmodule

/* rbus_req_fifo.sv */
`timescale 1ns/1ps

module rbus_req_fifo (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_wr,
  input  rbus_pkg::rbus_req_t i_req,
  input  logic                i_rd,
  output rbus_pkg::rbus_req_t o_req,
  output logic                o_nempty,
  output logic                o_af,
  output logic                o_err
);

  rbus_pkg::rbus_req_t mem [rbus_pkg::FIFO_DEPTH];

  logic [rbus_pkg::FIFO_AW-1:0] wr_ptr;
  logic [rbus_pkg::FIFO_AW-1:0] rd_ptr;
  logic [rbus_pkg::FIFO_AW-1:0] head_ptr;
  // one extra bit so a full queue is representable
  logic [rbus_pkg::FIFO_AW:0]   count;
  logic [rbus_pkg::FIFO_AW:0]   fill;
  logic [rbus_pkg::FIFO_AW:0]   rd_cnt;
  logic                         full;
  logic                         empty;
  logic                         do_wr;
  logic                         do_rd;

  assign full = (count == rbus_pkg::FIFO_DEPTH);
  assign empty = (count == '0);
  assign do_wr = i_wr & !full;
  assign do_rd = i_rd & !empty;

  // --------------------------------------------------
  // status
  // --------------------------------------------------

  // occupancy plus the write being done this cycle
  assign fill = count + {{rbus_pkg::FIFO_AW{1'b0}}, i_wr};
  assign o_af = (fill >= rbus_pkg::FIFO_DEPTH);

  // head as seen after the pop of this cycle
  // back-to-back headers must not see the same entry twice
  assign rd_cnt = {{rbus_pkg::FIFO_AW{1'b0}}, i_rd};
  assign head_ptr = rd_ptr + {{(rbus_pkg::FIFO_AW-1){1'b0}}, i_rd};
  assign o_nempty = (count > rd_cnt);
  assign o_req = mem[head_ptr];

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      o_err <= 1'b0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_wr && !do_rd)
        count <= count + 1'b1;
      else if (do_rd && !do_wr)
        count <= count - 1'b1;
      // overflow or underflow attempt
      o_err <= (i_wr & full) | (i_rd & empty);
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_wr)
      mem[wr_ptr] <= i_req;
  end

endmodule

/* rbus_req_bank.sv */
`timescale 1ns/1ps

module rbus_req_bank (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_wr,
  input  rbus_pkg::rbus_req_t i_req,
  input  logic                i_ack,
  output logic [3:0]          o_af,
  output logic                o_head_vld,
  output rbus_pkg::rbus_req_t o_head,
  output logic                o_err
);

  rbus_pkg::rbus_req_t heads [rbus_pkg::PRIO_NUM];

  logic [rbus_pkg::PRIO_NUM-1:0] wr;
  logic [rbus_pkg::PRIO_NUM-1:0] rd;
  logic [rbus_pkg::PRIO_NUM-1:0] nempty;
  logic [rbus_pkg::PRIO_NUM-1:0] err;
  logic [rbus_pkg::PRIO_W-1:0]   sel;
  // queue whose head was presented last cycle
  logic [rbus_pkg::PRIO_W-1:0]   sel_q;

  // --------------------------------------------------
  // one queue per priority
  // --------------------------------------------------

  for (genvar p = 0; p < rbus_pkg::PRIO_NUM; p++) begin : g_prio
    // route write by request priority
    assign wr[p] = i_wr & (i_req.pri == (rbus_pkg::PRIO_W)'(p));
    // ack pops the queue granted one cycle ago
    assign rd[p] = i_ack & (sel_q == (rbus_pkg::PRIO_W)'(p));

    rbus_req_fifo u_fifo (
      .clk      (clk),
      .rst      (rst),
      .i_wr     (wr[p]),
      .i_req    (i_req),
      .i_rd     (rd[p]),
      .o_req    (heads[p]),
      .o_nempty (nempty[p]),
      .o_af     (o_af[p]),
      .o_err    (err[p])
    );
  end

  // --------------------------------------------------
  // head select
  // --------------------------------------------------

  // highest nonempty priority wins
  always_comb begin
    sel = '0;
    for (int p = 0; p < rbus_pkg::PRIO_NUM; p++) begin
      if (nempty[p])
        sel = p[rbus_pkg::PRIO_W-1:0];
    end
  end

  assign o_head_vld = |nempty;
  assign o_head = heads[sel];
  assign o_err = |err;

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      sel_q <= '0;
    else
      sel_q <= sel;
  end

endmodule

/* rbus_grant_path.sv */
`timescale 1ns/1ps

module rbus_grant_path (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_sof,
  input  rbus_pkg::rbus_ctrl_t i_ctrl,
  input  rbus_pkg::rbus_word_t i_bus,
  input  logic                 i_skip,
  input  logic                 i_used,
  input  logic                 i_head_vld_s,
  input  rbus_pkg::rbus_req_t  i_head_s,
  input  logic                 i_head_vld_l,
  input  rbus_pkg::rbus_req_t  i_head_l,
  input  logic                 i_err_s,
  input  logic                 i_err_l,
  output logic                 o_ack_s,
  output logic                 o_ack_l,
  output logic                 o_sof,
  output rbus_pkg::rbus_ctrl_t o_ctrl,
  output rbus_pkg::rbus_word_t o_bus,
  output logic                 o_ff_err
);

  logic                 frm_len;
  logic                 hdr_free;
  logic                 en_s;
  logic                 en_l;
  logic                 s1_sof;
  logic                 s1_en_s;
  logic                 s1_en_l;
  logic                 s1_len;
  rbus_pkg::rbus_ctrl_t s1_ctrl;
  rbus_pkg::rbus_word_t s1_bus;
  rbus_pkg::rbus_req_t  s1_head;
  rbus_pkg::rbus_ctrl_t grant;

  // --------------------------------------------------
  // stage 1, grant enable
  // --------------------------------------------------

  assign frm_len = i_bus.header.frm_len;
  // header with ctrl valid low is free for a grant
  assign hdr_free = i_sof & !i_ctrl.valid;
  assign en_s = hdr_free & !frm_len & i_head_vld_s;
  assign en_l = hdr_free & frm_len & i_head_vld_l;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_sof <= 1'b0;
      s1_en_s <= 1'b0;
      s1_en_l <= 1'b0;
    end else begin
      s1_sof <= i_sof;
      s1_en_s <= en_s;
      s1_en_l <= en_l;
    end
  end

  // word and head request of the matching bank
  always_ff @(posedge clk) begin
    s1_ctrl <= i_ctrl;
    s1_bus <= i_bus;
    s1_len <= frm_len;
    s1_head <= frm_len ? i_head_l : i_head_s;
  end

  // pop the granted entry
  assign o_ack_s = s1_en_s;
  assign o_ack_l = s1_en_l;

  always_comb begin
    grant = '0;
    if (s1_en_s | s1_en_l) begin
      grant.valid = 1'b1;
      grant.len = s1_len;
      grant.pp = s1_head.pri;
      grant.did = s1_head.dev;
      grant.rid = s1_head.rid;
    end
  end

  // --------------------------------------------------
  // stage 2, output control
  // --------------------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_sof <= 1'b0;
      o_ctrl <= '0;
      o_ff_err <= 1'b0;
    end else begin
      o_sof <= s1_sof;
      // skipped request or taken header keeps its ctrl
      if (i_skip || (s1_sof && i_used))
        o_ctrl <= s1_ctrl;
      else if (s1_sof)
        o_ctrl <= grant;
      // accepted requests leave the ring here
      else
        o_ctrl <= '0;
      // sticky queue error
      o_ff_err <= o_ff_err | i_err_s | i_err_l;
    end
  end

  always_ff @(posedge clk) begin
    o_bus <= s1_bus;
  end

endmodule

/* rbus_d2r_mgr.sv */
`timescale 1ns/1ps

module rbus_d2r_mgr (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_sof,
  input  rbus_pkg::rbus_ctrl_t i_ctrl,
  input  rbus_pkg::rbus_word_t i_bus,
  output logic                 o_sof,
  output rbus_pkg::rbus_ctrl_t o_ctrl,
  output rbus_pkg::rbus_word_t o_bus,
  output logic                 o_ff_err
);

  // sorter to banks
  logic                wr_s;
  logic                wr_l;
  rbus_pkg::rbus_req_t req;
  // sorter to grant path
  logic                skip;
  logic                used;
  // bank status
  logic [3:0]          af_s;
  logic [3:0]          af_l;
  logic                head_vld_s;
  logic                head_vld_l;
  rbus_pkg::rbus_req_t head_s;
  rbus_pkg::rbus_req_t head_l;
  logic                err_s;
  logic                err_l;
  // grant path to banks
  logic                ack_s;
  logic                ack_l;

  // --------------------------------------------------
  // request capture
  // --------------------------------------------------

  rbus_req_sort u_sort (
    .clk    (clk),
    .rst    (rst),
    .i_sof  (i_sof),
    .i_ctrl (i_ctrl),
    .i_af_s (af_s),
    .i_af_l (af_l),
    .o_wr_s (wr_s),
    .o_wr_l (wr_l),
    .o_req  (req),
    .o_skip (skip),
    .o_used (used)
  );

  // short packet queues
  rbus_req_bank bank_s (
    .clk        (clk),
    .rst        (rst),
    .i_wr       (wr_s),
    .i_req      (req),
    .i_ack      (ack_s),
    .o_af       (af_s),
    .o_head_vld (head_vld_s),
    .o_head     (head_s),
    .o_err      (err_s)
  );

  // long packet queues
  rbus_req_bank bank_l (
    .clk        (clk),
    .rst        (rst),
    .i_wr       (wr_l),
    .i_req      (req),
    .i_ack      (ack_l),
    .o_af       (af_l),
    .o_head_vld (head_vld_l),
    .o_head     (head_l),
    .o_err      (err_l)
  );

  // --------------------------------------------------
  // grant and output
  // --------------------------------------------------

  rbus_grant_path u_grant (
    .clk          (clk),
    .rst          (rst),
    .i_sof        (i_sof),
    .i_ctrl       (i_ctrl),
    .i_bus        (i_bus),
    .i_skip       (skip),
    .i_used       (used),
    .i_head_vld_s (head_vld_s),
    .i_head_s     (head_s),
    .i_head_vld_l (head_vld_l),
    .i_head_l     (head_l),
    .i_err_s      (err_s),
    .i_err_l      (err_l),
    .o_ack_s      (ack_s),
    .o_ack_l      (ack_l),
    .o_sof        (o_sof),
    .o_ctrl       (o_ctrl),
    .o_bus        (o_bus),
    .o_ff_err     (o_ff_err)
  );

endmodule

/* rbus_d2r_mgr_assertions.sv */
`timescale 1ns/1ps

module rbus_d2r_mgr_assertions (
  input logic clk,
  input logic rst,
  input logic i_in_sof,
  input logic i_out_sof,
  input logic i_ff_err,
  input logic i_ack_s,
  input logic i_ack_l,
  input logic i_head_vld_s,
  input logic i_head_vld_l
);

  // --------------------------------------------------
  // ring level
  // --------------------------------------------------

  // legal traffic never over or underflows a queue
  a_no_ff_err: assert property (@(posedge clk) disable iff (rst) !i_ff_err)
    else $error("queue error flag raised");

  // every word leaves two cycles after it entered
  a_sof_delay: assert property (@(posedge clk) disable iff (rst)
    i_out_sof == $past(i_in_sof, 2))
    else $error("o_sof is not i_sof delayed by two cycles");

  // --------------------------------------------------
  // bank pops
  // --------------------------------------------------

  // ack pops the head shown one cycle earlier
  a_ack_s_head: assert property (@(posedge clk) disable iff (rst)
    i_ack_s |-> $past(i_head_vld_s))
    else $error("short bank ack without a valid head");

  a_ack_l_head: assert property (@(posedge clk) disable iff (rst)
    i_ack_l |-> $past(i_head_vld_l))
    else $error("long bank ack without a valid head");

endmodule

bind rbus_d2r_mgr rbus_d2r_mgr_assertions u_assert (
  .clk          (clk),
  .rst          (rst),
  .i_in_sof     (i_sof),
  .i_out_sof    (o_sof),
  .i_ff_err     (o_ff_err),
  .i_ack_s      (ack_s),
  .i_ack_l      (ack_l),
  .i_head_vld_s (head_vld_s),
  .i_head_vld_l (head_vld_l)
);

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk
);

  // 100 ns period, low for the first half
  initial begin
    o_clk = 1'b0;
    forever begin
      #50 o_clk = ~o_clk;
    end
  end

endmodule

/* tb_rbus_d2r_mgr.sv */
`timescale 1ns/1ps

module tb_rbus_d2r_mgr;

  // sizes of the vector file and the random phase
  localparam int N_VEC = 40;
  localparam int N_COL = 4;
  localparam int N_RAND = 300;
  localparam int QD = rbus_pkg::FIFO_DEPTH;

  // one word in flight through the DUT
  typedef struct packed {
    logic                 sof;
    rbus_pkg::rbus_ctrl_t ctrl;
    logic [31:0]          bus;
    logic                 has_file;
    rbus_pkg::rbus_ctrl_t file_ctrl;
  } exp_t;

  logic                 clk;
  logic                 rst;
  logic                 i_sof;
  rbus_pkg::rbus_ctrl_t i_ctrl;
  rbus_pkg::rbus_word_t i_bus;
  logic                 o_sof;
  rbus_pkg::rbus_ctrl_t o_ctrl;
  rbus_pkg::rbus_word_t o_bus;
  logic                 o_ff_err;

  logic [31:0] vec_mem [0:N_VEC*N_COL-1];
  exp_t        exp_q [$];

  // queue model indexed by class {len, pri}
  rbus_pkg::rbus_req_t m_req [8][QD];
  int m_vis [8][QD];
  int m_rd [8];
  int m_cnt [8];
  // class popped by the previous word or -1
  int prev_pop;
  int word_idx;
  int errors;
  int checks;
  int seed;

  tb_clock_gen u_clk (
    .o_clk (clk)
  );

  rbus_d2r_mgr dut (
    .clk      (clk),
    .rst      (rst),
    .i_sof    (i_sof),
    .i_ctrl   (i_ctrl),
    .i_bus    (i_bus),
    .o_sof    (o_sof),
    .o_ctrl   (o_ctrl),
    .o_bus    (o_bus),
    .o_ff_err (o_ff_err)
  );

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------

  // expected output ctrl for one input word
  task automatic predict(input logic sof, input rbus_pkg::rbus_ctrl_t ctrl,
                         input logic [31:0] bus, output rbus_pkg::rbus_ctrl_t exp);
    int cls;
    int occ;
    int pop;
    int slot;
    int p;
    exp = '0;
    pop = -1;
    if (!sof && ctrl.valid) begin
      cls = int'({ctrl.len, ctrl.pp});
      // a pop granted one word ago has not left the queue yet
      occ = m_cnt[cls] + ((prev_pop == cls) ? 1 : 0);
      if (occ < QD) begin
        slot = (m_rd[cls] + m_cnt[cls]) % QD;
        m_req[cls][slot] = {ctrl.pp, ctrl.did, ctrl.rid};
        // written one cycle later and grantable the cycle after
        m_vis[cls][slot] = word_idx + 2;
        m_cnt[cls]++;
      end else begin
        exp = ctrl;
      end
    end else if (sof && ctrl.valid) begin
      // used header passes as is
      exp = ctrl;
    end else if (sof) begin
      for (p = 3; p >= 0; p--) begin
        cls = bus[31] ? 4 + p : p;
        if (pop < 0 && m_cnt[cls] > 0 && m_vis[cls][m_rd[cls]] <= word_idx) begin
          exp.valid = 1'b1;
          exp.len = bus[31];
          exp.pp = m_req[cls][m_rd[cls]].pri;
          exp.did = m_req[cls][m_rd[cls]].dev;
          exp.rid = m_req[cls][m_rd[cls]].rid;
          m_rd[cls] = (m_rd[cls] + 1) % QD;
          m_cnt[cls]--;
          pop = cls;
        end
      end
    end
    prev_pop = pop;
    word_idx++;
  endtask

  // --------------------------------------------------
  // drive and check
  // --------------------------------------------------

  task automatic check_oldest();
    exp_t e;
    e = exp_q.pop_front();
    checks++;
    if (o_sof !== e.sof) begin
      errors++;
      $display("error at %0t: o_sof expected %0b got %0b", $time, e.sof, o_sof);
    end
    if (o_ctrl !== e.ctrl) begin
      errors++;
      $display("error at %0t: o_ctrl expected %h got %h", $time, e.ctrl, o_ctrl);
    end
    if (e.has_file && o_ctrl !== e.file_ctrl) begin
      errors++;
      $display("error at %0t: o_ctrl (vector file) expected %h got %h",
               $time, e.file_ctrl, o_ctrl);
    end
    if (o_bus.raw !== e.bus) begin
      errors++;
      $display("error at %0t: o_bus expected %h got %h", $time, e.bus, o_bus.raw);
    end
    if (o_ff_err !== 1'b0) begin
      errors++;
      $display("error at %0t: o_ff_err expected 0 got %0b", $time, o_ff_err);
    end
  endtask

  // one word per falling edge after checking the word from two steps back
  task automatic step(input logic sof, input rbus_pkg::rbus_ctrl_t ctrl,
                      input logic [31:0] bus, input logic has_file,
                      input rbus_pkg::rbus_ctrl_t file_ctrl);
    exp_t e;
    rbus_pkg::rbus_ctrl_t pc;
    @(negedge clk);
    if (exp_q.size() == 2)
      check_oldest();
    predict(sof, ctrl, bus, pc);
    e.sof = sof;
    e.ctrl = pc;
    e.bus = bus;
    e.has_file = has_file;
    e.file_ctrl = file_ctrl;
    exp_q.push_back(e);
    i_sof = sof;
    i_ctrl = ctrl;
    i_bus = bus;
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    int i;
    int c;
    logic [31:0] r_word;
    logic [31:0] r_ctrl;
    logic [31:0] r_bus;
    rst = 1'b1;
    i_sof = 1'b0;
    i_ctrl = '0;
    i_bus = '0;
    errors = 0;
    checks = 0;
    prev_pop = -1;
    word_idx = 0;
    seed = 32'hd315_c244;
    for (c = 0; c < 8; c++) begin
      m_rd[c] = 0;
      m_cnt[c] = 0;
    end
    $readmemh("rbus_d2r_vectors.txt", vec_mem);

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // idle after reset
    if (o_sof !== 1'b0) begin
      errors++;
      $display("error at %0t: o_sof expected 0 got %0b", $time, o_sof);
    end
    if (o_ctrl !== '0) begin
      errors++;
      $display("error at %0t: o_ctrl expected 000 got %h", $time, o_ctrl);
    end
    if (o_ff_err !== 1'b0) begin
      errors++;
      $display("error at %0t: o_ff_err expected 0 got %0b", $time, o_ff_err);
    end

    if ($isunknown(vec_mem[0])) begin
      errors++;
      $display("vector file rbus_d2r_vectors.txt could not be read");
    end else begin
      for (i = 0; i < N_VEC; i++) begin
        step(vec_mem[N_COL*i][0], vec_mem[N_COL*i+1][11:0], vec_mem[N_COL*i+2],
             1'b1, vec_mem[N_COL*i+3][11:0]);
      end
    end

    // random filler with about half headers
    for (i = 0; i < N_RAND; i++) begin
      r_word = $random(seed);
      r_ctrl = $random(seed);
      r_bus = $random(seed);
      step(r_word[0], r_ctrl[11:0], r_bus, 1'b0, '0);
    end

    // drain the pipeline
    while (exp_q.size() > 0) begin
      @(negedge clk);
      i_sof = 1'b0;
      i_ctrl = '0;
      i_bus = '0;
      check_oldest();
    end

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog sized from the word count
  initial begin
    #((N_VEC + N_RAND + 50) * 100);
    $display("watchdog timeout, the run did not finish in time");
    $display("Simulation failed");
    $finish;
  end

endmodule

/* rbus_d2r_vectors.txt */
// columns: sof ctrl bus expected_ctrl, all hex, ctrl = {valid len pp[1:0] did[3:0] rid[3:0]}
// header words carry frm_len in bus bit 31
// plain data and a header with empty queues
0 000 12345678 000
0 000 9abcdef0 000
1 000 00000001 000
// short request, long header gets nothing, short header is granted
0 935 00000010 000
0 000 00000011 000
1 000 80000000 000
1 000 00000002 935
// long requests over three priorities
0 c11 00000020 000
0 e22 00000021 000
0 e43 00000022 000
0 f54 00000023 000
0 000 00000024 000
1 000 80000003 f54
1 000 80000004 e22
1 000 80000005 e43
1 000 80000006 c11
1 000 80000007 000
// used header passes and leaves the queued request alone
0 a67 00000030 000
0 000 00000031 000
1 8ab 00000008 8ab
1 000 00000009 a67
// sixteen short priority 0 requests, the seventeenth stays on the ring
0 810 00000040 000
0 811 00000041 000
0 812 00000042 000
0 813 00000043 000
0 814 00000044 000
0 815 00000045 000
0 816 00000046 000
0 817 00000047 000
0 818 00000048 000
0 819 00000049 000
0 81a 0000004a 000
0 81b 0000004b 000
0 81c 0000004c 000
0 81d 0000004d 000
0 81e 0000004e 000
0 81f 0000004f 000
0 820 00000050 820
1 000 0000000a 810
1 000 0000000b 811

/* build.f */
rbus_pkg.sv
rbus_req_sort.sv
rbus_req_fifo.sv
rbus_req_bank.sv
rbus_grant_path.sv
rbus_d2r_mgr.sv
rbus_d2r_mgr_assertions.sv
tb_clock_gen.sv
tb_rbus_d2r_mgr.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rbus_d2r_mgr
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run ended without a result line"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
